//--- Makefile
TOOL       := verilator
TOP        := tb_xpu
FILELIST   := build.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
PASS_MSG   := RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
src/xpu_pkg.sv
src/xpu_regs.sv
src/tsf_timer.sv
src/phy_rx_parse.sv
src/xpu_top.sv
tests/tb_clk_gen.sv
tests/tb_xpu.sv

//--- src/phy_rx_parse.sv
// rx header parser: captures frame control, addr1 and addr2 from the demod byte stream
`timescale 1ns/1ps

module phy_rx_parse (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   pkt_header_valid_strobe_i,   // start of a new header
  input  logic                   byte_in_strobe_i,
  input  logic [7:0]             byte_in_i,
  input  logic [15:0]            byte_count_i,
  input  xpu_pkg::mac_addr_t     self_mac_i,
  output xpu_pkg::rx_hdr_t       hdr_o,
  output xpu_pkg::rx_hdr_valid_t hdr_valid_o,
  output logic                   pkt_for_me_o
);

  localparam logic [15:0] ADDR1_FIRST = xpu_pkg::FC_LAST_BYTE + 16'd1;
  localparam logic [15:0] ADDR2_FIRST = xpu_pkg::ADDR1_LAST_BYTE + 16'd1;

  xpu_pkg::rx_hdr_t       hdr_q;
  xpu_pkg::rx_hdr_valid_t valid_q;
  logic                   in_fc;
  logic                   in_addr1;
  logic                   in_addr2;
  logic [2:0]             addr1_idx;   // byte within addr1
  logic [2:0]             addr2_idx;

  // which field the current byte index falls in
  always_comb begin
    in_fc     = byte_count_i <= xpu_pkg::FC_LAST_BYTE;
    in_addr1  = (byte_count_i >= ADDR1_FIRST) && (byte_count_i <= xpu_pkg::ADDR1_LAST_BYTE);
    in_addr2  = (byte_count_i >= ADDR2_FIRST) && (byte_count_i <= xpu_pkg::ADDR2_LAST_BYTE);
    addr1_idx = 3'(byte_count_i - ADDR1_FIRST);
    addr2_idx = 3'(byte_count_i - ADDR2_FIRST);
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || pkt_header_valid_strobe_i) begin
      hdr_q   <= '0;
      valid_q <= '0;
    end else if (byte_in_strobe_i) begin
      // little endian, byte k into bits 8k+7:8k
      if (in_fc) begin
        hdr_q.fc_di[{byte_count_i[1:0], 3'b000} +: 8] <= byte_in_i;
      end
      if (in_addr1) begin
        hdr_q.addr1[{addr1_idx, 3'b000} +: 8] <= byte_in_i;
      end
      if (in_addr2) begin
        hdr_q.addr2[{addr2_idx, 3'b000} +: 8] <= byte_in_i;
      end

      // valids one cycle after the last byte
      if (byte_count_i == xpu_pkg::FC_LAST_BYTE) begin
        valid_q.fc_valid <= 1'b1;
      end
      if (byte_count_i == xpu_pkg::ADDR1_LAST_BYTE) begin
        valid_q.addr1_valid <= 1'b1;
      end
      if (byte_count_i == xpu_pkg::ADDR2_LAST_BYTE) begin
        valid_q.addr2_valid <= 1'b1;
      end
    end
  end

  assign hdr_o        = hdr_q;
  assign hdr_valid_o  = valid_q;
  assign pkt_for_me_o = valid_q.addr1_valid && (hdr_q.addr1 == self_mac_i);

  // valids are sticky for the whole frame
  a_valid_sticky: assert property (@(posedge clk_i)
    (|($past(valid_q) & ~valid_q)) |-> $past(pkt_header_valid_strobe_i || rst_i))
    else $error("header valid dropped without header strobe or reset");

endmodule

//--- src/tsf_timer.sv
// tsf timer: 64-bit microsecond counter with 1 MHz pulse and software load
`timescale 1ns/1ps

module tsf_timer #(
  parameter int CLK_PER_US = 100   // clock cycles per microsecond
) (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          tsf_load_i,
  input  xpu_pkg::tsf_t tsf_load_val_i,
  output xpu_pkg::tsf_t tsf_o,
  output logic          tsf_pulse_1m_o
);

  localparam int PRE_W = (CLK_PER_US > 1) ? $clog2(CLK_PER_US) : 1;
  localparam logic [PRE_W-1:0] PRE_TOP = PRE_W'(CLK_PER_US - 1);

  logic [PRE_W-1:0] pre_cnt_q;   // cycles within the current us
  logic             pulse_q;
  xpu_pkg::tsf_t    tsf_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pre_cnt_q <= '0;
      pulse_q   <= 1'b0;
      tsf_q     <= '0;
    end else if (tsf_load_i) begin
      // restart the us phase at the load point
      pre_cnt_q <= '0;
      pulse_q   <= 1'b0;
      tsf_q     <= tsf_load_val_i;
    end else if (pre_cnt_q == PRE_TOP) begin
      pre_cnt_q <= '0;
      pulse_q   <= 1'b1;
      tsf_q     <= tsf_q + 64'd1;   // same edge as the pulse
    end else begin
      pre_cnt_q <= pre_cnt_q + 1'b1;
      pulse_q   <= 1'b0;
    end
  end

  assign tsf_o          = tsf_q;
  assign tsf_pulse_1m_o = pulse_q;

  // counter moves by one exactly with the pulse unless software loads it
  a_tsf_step: assert property (@(posedge clk_i) disable iff (rst_i)
    !tsf_load_i |=> (tsf_pulse_1m_o ? (tsf_o == $past(tsf_o) + 64'd1)
                                    : (tsf_o == $past(tsf_o))))
    else $error("tsf_o changed without a 1 MHz pulse");

endmodule

//--- src/xpu_pkg.sv
// xpu shared widths, register map, phy timing defaults and header structs
package xpu_pkg;

  typedef logic [5:0]  reg_addr_t;    // register number
  typedef logic [31:0] reg_data_t;    // register word
  typedef logic [63:0] tsf_t;         // tsf time in us
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] fc_di_t;       // duration in upper half
  typedef logic [3:0]  band_t;        // 1 is 2.4GHz
  typedef logic [7:0]  channel_t;
  typedef logic [6:0]  ifs_time_t;    // us
  typedef logic [4:0]  sym_time_t;

  typedef struct packed {
    band_t     band;
    channel_t  channel;
    logic      erp_short_slot;
    mac_addr_t mac_addr;
  } xpu_cfg_t;

  typedef struct packed {
    ifs_time_t preamble_sig_time;
    sym_time_t ofdm_symbol_time;
    ifs_time_t slot_time;
    ifs_time_t sifs_time;
  } phy_timing_t;

  typedef struct packed {
    fc_di_t    fc_di;
    mac_addr_t addr1;   // receiver
    mac_addr_t addr2;   // transmitter
  } rx_hdr_t;

  typedef struct packed {
    logic fc_valid;
    logic addr1_valid;
    logic addr2_valid;
  } rx_hdr_valid_t;

  // register numbers
  localparam reg_addr_t REG_SOFT_RST    = 6'd0;   // bit 3 resets the parser
  localparam reg_addr_t REG_TSF_LOAD_LO = 6'd2;
  localparam reg_addr_t REG_TSF_LOAD_HI = 6'd3;   // msb rising edge loads tsf
  localparam reg_addr_t REG_BAND_CH     = 6'd4;
  localparam reg_addr_t REG_IFS_OVR     = 6'd9;
  localparam reg_addr_t REG_MAC_LO      = 6'd30;
  localparam reg_addr_t REG_MAC_HI      = 6'd31;
  localparam reg_addr_t REG_TSF_LO      = 6'd58;
  localparam reg_addr_t REG_TSF_HI      = 6'd59;
  localparam reg_addr_t REG_ADDR2_RB    = 6'd62;
  localparam reg_addr_t REG_VERSION     = 6'd63;

  localparam reg_data_t HW_VERSION = 32'h0000_0A01;

  // phy timing defaults
  localparam band_t     BAND_2G4          = 4'd1;
  localparam ifs_time_t PREAMBLE_SIG_DEF  = 7'd20;
  localparam sym_time_t OFDM_SYM_DEF      = 5'd4;
  localparam ifs_time_t SLOT_LONG_DEF     = 7'd20;  // 2.4GHz without short slot
  localparam ifs_time_t SLOT_SHORT_DEF    = 7'd9;
  localparam ifs_time_t SIFS_2G4_DEF      = 7'd10;
  localparam ifs_time_t SIFS_5G_DEF       = 7'd16;

  // last byte index of each header field
  localparam logic [15:0] FC_LAST_BYTE    = 16'd3;
  localparam logic [15:0] ADDR1_LAST_BYTE = 16'd9;
  localparam logic [15:0] ADDR2_LAST_BYTE = 16'd15;

endpackage

//--- src/xpu_regs.sv
// xpu register file with registered read mux, tsf load trigger and phy timing decode
`timescale 1ns/1ps

module xpu_regs (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  reg_wr_i,
  input  xpu_pkg::reg_addr_t    reg_addr_i,
  input  xpu_pkg::reg_data_t    reg_wdata_i,
  input  xpu_pkg::tsf_t         tsf_i,        // runtime tsf for readback
  input  xpu_pkg::mac_addr_t    addr2_i,      // parsed transmitter address
  output xpu_pkg::reg_data_t    reg_rdata_o,
  output xpu_pkg::xpu_cfg_t     cfg_o,
  output xpu_pkg::phy_timing_t  timing_o,
  output logic                  tsf_load_o,
  output xpu_pkg::tsf_t         tsf_load_val_o,
  output logic                  parser_rst_o
);

  xpu_pkg::reg_data_t soft_rst_q;
  xpu_pkg::reg_data_t tsf_load_lo_q;
  xpu_pkg::reg_data_t tsf_load_hi_q;
  xpu_pkg::reg_data_t band_ch_q;
  xpu_pkg::reg_data_t ifs_ovr_q;
  xpu_pkg::reg_data_t mac_lo_q;
  xpu_pkg::reg_data_t mac_hi_q;
  xpu_pkg::reg_data_t rdata_q;
  logic               tsf_load_q;
  logic               load_hi_wr;

  assign load_hi_wr = reg_wr_i && (reg_addr_i == xpu_pkg::REG_TSF_LOAD_HI);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      soft_rst_q    <= '0;
      tsf_load_lo_q <= '0;
      tsf_load_hi_q <= '0;
      band_ch_q     <= '0;
      ifs_ovr_q     <= '0;
      mac_lo_q      <= '0;
      mac_hi_q      <= '0;
    end else if (reg_wr_i) begin
      case (reg_addr_i)
        xpu_pkg::REG_SOFT_RST:    soft_rst_q    <= reg_wdata_i;
        xpu_pkg::REG_TSF_LOAD_LO: tsf_load_lo_q <= reg_wdata_i;
        xpu_pkg::REG_TSF_LOAD_HI: tsf_load_hi_q <= reg_wdata_i;
        xpu_pkg::REG_BAND_CH:     band_ch_q     <= reg_wdata_i;
        xpu_pkg::REG_IFS_OVR:     ifs_ovr_q     <= reg_wdata_i;
        xpu_pkg::REG_MAC_LO:      mac_lo_q      <= reg_wdata_i;
        xpu_pkg::REG_MAC_HI:      mac_hi_q      <= reg_wdata_i;
        default: ;                                 // read-only or unused
      endcase
    end
  end

  // load only when the msb goes 0 -> 1
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tsf_load_q <= 1'b0;
    end else begin
      tsf_load_q <= load_hi_wr && reg_wdata_i[31] && !tsf_load_hi_q[31];
    end
  end

  assign tsf_load_o     = tsf_load_q;
  assign tsf_load_val_o = {tsf_load_hi_q, tsf_load_lo_q};   // msb is also the trigger
  assign parser_rst_o   = rst_i | soft_rst_q[3];

  // config decode
  assign cfg_o.band           = band_ch_q[19:16];
  assign cfg_o.channel        = band_ch_q[7:0];
  assign cfg_o.erp_short_slot = band_ch_q[24];
  assign cfg_o.mac_addr       = {mac_hi_q[15:0], mac_lo_q};

  always_comb begin
    if (ifs_ovr_q[31]) begin
      // debug override of all four values
      timing_o.preamble_sig_time = ifs_ovr_q[30:24];
      timing_o.ofdm_symbol_time  = ifs_ovr_q[23:19];
      timing_o.slot_time         = {2'b00, ifs_ovr_q[18:14]};
      timing_o.sifs_time         = ifs_ovr_q[13:7];
    end else begin
      timing_o.preamble_sig_time = xpu_pkg::PREAMBLE_SIG_DEF;
      timing_o.ofdm_symbol_time  = xpu_pkg::OFDM_SYM_DEF;
      if (cfg_o.band == xpu_pkg::BAND_2G4) begin
        timing_o.slot_time = cfg_o.erp_short_slot ? xpu_pkg::SLOT_SHORT_DEF
                                                  : xpu_pkg::SLOT_LONG_DEF;
        timing_o.sifs_time = xpu_pkg::SIFS_2G4_DEF;
      end else begin
        timing_o.slot_time = xpu_pkg::SLOT_SHORT_DEF;
        timing_o.sifs_time = xpu_pkg::SIFS_5G_DEF;
      end
    end
  end

  // registered read, one cycle behind the address
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdata_q <= '0;
    end else begin
      case (reg_addr_i)
        xpu_pkg::REG_SOFT_RST:    rdata_q <= soft_rst_q;
        xpu_pkg::REG_TSF_LOAD_LO: rdata_q <= tsf_load_lo_q;
        xpu_pkg::REG_TSF_LOAD_HI: rdata_q <= tsf_load_hi_q;
        xpu_pkg::REG_BAND_CH:     rdata_q <= band_ch_q;
        xpu_pkg::REG_IFS_OVR:     rdata_q <= ifs_ovr_q;
        xpu_pkg::REG_MAC_LO:      rdata_q <= mac_lo_q;
        xpu_pkg::REG_MAC_HI:      rdata_q <= mac_hi_q;
        xpu_pkg::REG_TSF_LO:      rdata_q <= tsf_i[31:0];
        xpu_pkg::REG_TSF_HI:      rdata_q <= tsf_i[63:32];
        // addr2 bytes 2..5, byte 2 on top
        xpu_pkg::REG_ADDR2_RB:    rdata_q <= {addr2_i[23:16], addr2_i[31:24],
                                              addr2_i[39:32], addr2_i[47:40]};
        xpu_pkg::REG_VERSION:     rdata_q <= xpu_pkg::HW_VERSION;
        default:                  rdata_q <= '0;
      endcase
    end
  end

  assign reg_rdata_o = rdata_q;

  // repeated writes of the msb must not retrigger the timer load
  a_load_single_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    tsf_load_o |=> !tsf_load_o)
    else $error("tsf_load_o high two cycles in a row");

endmodule

//--- src/xpu_top.sv
// xpu lower-mac top: register port, tsf timer and rx header parser
`timescale 1ns/1ps

module xpu_top #(
  parameter int CLK_PER_US = 100
) (
  input  logic                   clk_i,
  input  logic                   rst_i,

  // register port
  input  logic                   reg_wr_i,
  input  xpu_pkg::reg_addr_t     reg_addr_i,
  input  xpu_pkg::reg_data_t     reg_wdata_i,
  output xpu_pkg::reg_data_t     reg_rdata_o,

  // demodulated byte stream
  input  logic                   pkt_header_valid_strobe_i,
  input  logic                   byte_in_strobe_i,
  input  logic [7:0]             byte_in_i,
  input  logic [15:0]            byte_count_i,

  output xpu_pkg::xpu_cfg_t      cfg_o,
  output xpu_pkg::phy_timing_t   timing_o,
  output xpu_pkg::tsf_t          tsf_o,
  output logic                   tsf_pulse_1m_o,
  output xpu_pkg::rx_hdr_t       hdr_o,
  output xpu_pkg::rx_hdr_valid_t hdr_valid_o,
  output logic                   pkt_for_me_o
);

  logic          tsf_load;
  xpu_pkg::tsf_t tsf_load_val;
  logic          parser_rst;   // global or soft reset

  xpu_regs u_regs (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .reg_wr_i       (reg_wr_i),
    .reg_addr_i     (reg_addr_i),
    .reg_wdata_i    (reg_wdata_i),
    .tsf_i          (tsf_o),
    .addr2_i        (hdr_o.addr2),
    .reg_rdata_o    (reg_rdata_o),
    .cfg_o          (cfg_o),
    .timing_o       (timing_o),
    .tsf_load_o     (tsf_load),
    .tsf_load_val_o (tsf_load_val),
    .parser_rst_o   (parser_rst)
  );

  tsf_timer #(
    .CLK_PER_US (CLK_PER_US)
  ) u_tsf_timer (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .tsf_load_i     (tsf_load),
    .tsf_load_val_i (tsf_load_val),
    .tsf_o          (tsf_o),
    .tsf_pulse_1m_o (tsf_pulse_1m_o)
  );

  phy_rx_parse u_rx_parse (
    .clk_i                     (clk_i),
    .rst_i                     (parser_rst),
    .pkt_header_valid_strobe_i (pkt_header_valid_strobe_i),
    .byte_in_strobe_i          (byte_in_strobe_i),
    .byte_in_i                 (byte_in_i),
    .byte_count_i              (byte_count_i),
    .self_mac_i                (cfg_o.mac_addr),   // station address from regs
    .hdr_o                     (hdr_o),
    .hdr_valid_o               (hdr_valid_o),
    .pkt_for_me_o              (pkt_for_me_o)
  );

endmodule

//--- tests/tb_clk_gen.sv
// testbench clock and reset source: 8 ns clock, reset held for a number of cycles
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;   // 8 ns period
  end

  // release just after an edge, like the other inputs
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

//--- tests/tb_xpu.sv
// xpu testbench with a table of register, timing and frame stimulus plus tsf and clear checks
`timescale 1ns/1ps

module tb_xpu;

  localparam int CLK_PER_US = 5;
  localparam int RST_CYCLES = 10;
  localparam int SEED       = 15;
  localparam logic [1:0] ROW_WRITE = 2'd0;
  localparam logic [1:0] ROW_READ  = 2'd1;
  localparam logic [1:0] ROW_FRAME = 2'd2;

  typedef struct packed {
    logic [1:0]         kind;
    xpu_pkg::reg_addr_t addr;
    xpu_pkg::reg_data_t data;         // bit 0 of a frame row aims addr1 at our mac
    xpu_pkg::reg_data_t expect_val;
  } stim_row_t;

  logic                   clk;
  logic                   rst;
  logic                   reg_wr;
  xpu_pkg::reg_addr_t     reg_addr;
  xpu_pkg::reg_data_t     reg_wdata;
  xpu_pkg::reg_data_t     reg_rdata;
  logic                   hdr_strobe;
  logic                   byte_strobe;
  logic [7:0]             byte_in;
  logic [15:0]            byte_count;
  xpu_pkg::xpu_cfg_t      cfg;
  xpu_pkg::phy_timing_t   timing;
  xpu_pkg::tsf_t          tsf;
  logic                   tsf_pulse;
  xpu_pkg::rx_hdr_t       hdr;
  xpu_pkg::rx_hdr_valid_t hdr_valid;
  logic                   pkt_for_me;

  stim_row_t rows[$];
  int cycle_cnt   = 0;
  int cycle_limit = 0;
  int errors      = 0;
  xpu_pkg::reg_data_t m_band_ch = '0;   // shadow of the writable registers
  xpu_pkg::reg_data_t m_ifs_ovr = '0;
  xpu_pkg::reg_data_t m_mac_lo  = '0;
  xpu_pkg::reg_data_t m_mac_hi  = '0;

  tb_clk_gen #(.RST_CYCLES(RST_CYCLES)) u_clk_gen (.clk_o(clk), .rst_o(rst));

  xpu_top #(.CLK_PER_US(CLK_PER_US)) DUT (
    .clk_i(clk), .rst_i(rst),
    .reg_wr_i(reg_wr), .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata),
    .reg_rdata_o(reg_rdata),
    .pkt_header_valid_strobe_i(hdr_strobe), .byte_in_strobe_i(byte_strobe),
    .byte_in_i(byte_in), .byte_count_i(byte_count),
    .cfg_o(cfg), .timing_o(timing), .tsf_o(tsf), .tsf_pulse_1m_o(tsf_pulse),
    .hdr_o(hdr), .hdr_valid_o(hdr_valid), .pkt_for_me_o(pkt_for_me)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: test did not finish within %0d clock cycles", cycle_limit);
      $display("RESULT: FAIL");
      $fatal(1, "simulation timeout");
    end
  end

  task automatic stop_run();
    errors++;
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first failing check");
  endtask

  task automatic check_word(input string name, input xpu_pkg::reg_data_t got,
                            input xpu_pkg::reg_data_t exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%08h expected 0x%08h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_timing(input string name, input xpu_pkg::phy_timing_t got,
                              input xpu_pkg::phy_timing_t exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%07h expected 0x%07h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_addr(input string name, input xpu_pkg::mac_addr_t got,
                            input xpu_pkg::mac_addr_t exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%012h expected 0x%012h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_tsf(input string name, input xpu_pkg::tsf_t got,
                           input xpu_pkg::tsf_t exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%016h expected 0x%016h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_valids(input logic fc, input logic a1, input logic a2);
    check_bit("hdr_valid_o.fc_valid", hdr_valid.fc_valid, fc);
    check_bit("hdr_valid_o.addr1_valid", hdr_valid.addr1_valid, a1);
    check_bit("hdr_valid_o.addr2_valid", hdr_valid.addr2_valid, a2);
  endtask

  // band rule or the four override fields when bit 31 is set
  function automatic xpu_pkg::phy_timing_t expected_timing();
    xpu_pkg::phy_timing_t t;
    logic is_2g4;
    is_2g4 = (m_band_ch[19:16] == 4'd1);
    if (m_ifs_ovr[31]) begin
      t.preamble_sig_time = m_ifs_ovr[30:24];
      t.ofdm_symbol_time  = m_ifs_ovr[23:19];
      t.slot_time         = {2'b00, m_ifs_ovr[18:14]};
      t.sifs_time         = m_ifs_ovr[13:7];
    end else begin
      t.preamble_sig_time = 7'd20;
      t.ofdm_symbol_time  = 5'd4;
      t.slot_time         = (is_2g4 && !m_band_ch[24]) ? 7'd20 : 7'd9;
      t.sifs_time         = is_2g4 ? 7'd10 : 7'd16;
    end
    return t;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic reg_write(input xpu_pkg::reg_addr_t addr, input xpu_pkg::reg_data_t data);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    next_cycle();
    reg_wr    = 1'b0;
    case (addr)
      xpu_pkg::REG_BAND_CH: m_band_ch = data;
      xpu_pkg::REG_IFS_OVR: m_ifs_ovr = data;
      xpu_pkg::REG_MAC_LO:  m_mac_lo  = data;
      xpu_pkg::REG_MAC_HI:  m_mac_hi  = data;
      default: ;
    endcase
  endtask

  task automatic reg_read(input xpu_pkg::reg_addr_t addr, output xpu_pkg::reg_data_t data);
    reg_addr = addr;
    next_cycle();
    data = reg_rdata;
  endtask

  task automatic check_config();
    check_word("cfg_o.band", 32'(cfg.band), 32'(m_band_ch[19:16]));
    check_word("cfg_o.channel", 32'(cfg.channel), 32'(m_band_ch[7:0]));
    check_bit("cfg_o.erp_short_slot", cfg.erp_short_slot, m_band_ch[24]);
    check_addr("cfg_o.mac_addr", cfg.mac_addr, {m_mac_hi[15:0], m_mac_lo});
    check_timing("timing_o", timing, expected_timing());
  endtask

  task automatic run_frame(input logic aim_at_me, input logic exp_for_me);
    logic [7:0] frame [16];
    xpu_pkg::mac_addr_t my_mac;
    xpu_pkg::fc_di_t    exp_fc;
    xpu_pkg::mac_addr_t exp_a1;
    xpu_pkg::mac_addr_t exp_a2;
    xpu_pkg::reg_data_t rb;
    int k;
    my_mac = {m_mac_hi[15:0], m_mac_lo};
    for (k = 0; k < 16; k++) frame[k] = 8'($urandom);
    for (k = 0; k < 6; k++) begin
      if (aim_at_me) frame[4 + k] = my_mac[8*k +: 8];
      exp_a1[8*k +: 8] = frame[4 + k];
    end
    if (!aim_at_me && exp_a1 == my_mac) begin
      frame[4] = ~frame[4];   // keep a random addr1 off our mac
      exp_a1[7:0] = frame[4];
    end
    for (k = 0; k < 4; k++) exp_fc[8*k +: 8] = frame[k];
    for (k = 0; k < 6; k++) exp_a2[8*k +: 8] = frame[10 + k];

    hdr_strobe = 1'b1;
    next_cycle();
    hdr_strobe = 1'b0;
    check_valids(1'b0, 1'b0, 1'b0);
    check_bit("pkt_for_me_o", pkt_for_me, 1'b0);
    for (k = 0; k < 16; k++) begin
      byte_strobe = 1'b1;
      byte_count  = 16'(k);
      byte_in     = frame[k];
      next_cycle();
      check_valids(k >= 3, k >= 9, k >= 15);
      check_bit("pkt_for_me_o", pkt_for_me, (k >= 9) && exp_for_me);
    end
    byte_strobe = 1'b0;
    byte_count  = '0;
    byte_in     = '0;
    check_word("hdr_o.fc_di", hdr.fc_di, exp_fc);
    check_addr("hdr_o.addr1", hdr.addr1, exp_a1);
    check_addr("hdr_o.addr2", hdr.addr2, exp_a2);
    reg_read(xpu_pkg::REG_ADDR2_RB, rb);
    check_word("reg_rdata_o addr2 readback", rb, {frame[12], frame[13], frame[14], frame[15]});
  endtask

  task automatic run_tsf_checks();
    xpu_pkg::reg_data_t lo;
    xpu_pkg::reg_data_t hi;
    xpu_pkg::reg_data_t rb;
    xpu_pkg::tsf_t      prev;
    int pulses;
    int waited;
    lo = $urandom;
    hi = $urandom & 32'h7fff_ffff;
    reg_write(xpu_pkg::REG_TSF_LOAD_LO, lo);
    reg_write(xpu_pkg::REG_TSF_LOAD_HI, hi);    // msb low arms the trigger
    reg_read(xpu_pkg::REG_TSF_LOAD_HI, rb);
    check_word("reg_rdata_o tsf load hi", rb, hi);
    hi[31] = 1'b1;
    reg_write(xpu_pkg::REG_TSF_LOAD_HI, hi);
    next_cycle();
    check_tsf("tsf_o after load", tsf, {hi, lo});
    prev   = tsf;
    pulses = 0;
    waited = 0;
    while (pulses < 4) begin
      next_cycle();
      waited++;
      if (tsf_pulse) begin
        check_tsf("tsf_o at pulse", tsf, prev + 64'd1);
        check_word("tsf_pulse_1m_o spacing", 32'(waited), 32'(CLK_PER_US));
        pulses++;
        waited = 0;
      end else begin
        check_tsf("tsf_o between pulses", tsf, prev);
      end
      prev = tsf;
    end
    // address sits in the cycle that ends with the next pulse
    repeat (CLK_PER_US - 1) next_cycle();
    prev = tsf;   // value seen while the address is presented
    reg_read(xpu_pkg::REG_TSF_LO, rb);
    check_bit("tsf_pulse_1m_o during tsf lo read", tsf_pulse, 1'b1);
    check_word("reg_rdata_o tsf lo", rb, prev[31:0]);
    prev = tsf;
    reg_read(xpu_pkg::REG_TSF_HI, rb);
    check_word("reg_rdata_o tsf hi", rb, prev[63:32]);
    prev = tsf;
    reg_write(xpu_pkg::REG_TSF_LOAD_HI, hi ^ 32'h0000_ffff);   // msb stays 1
    next_cycle();
    next_cycle();
    check_bit("tsf_o without reload", (tsf - prev) <= 64'd1, 1'b1);
  endtask

  task automatic run_clear_checks();
    xpu_pkg::reg_data_t rb;
    run_frame(1'b1, 1'b1);
    reg_write(xpu_pkg::REG_SOFT_RST, 32'h0000_0008);
    next_cycle();
    check_valids(1'b0, 1'b0, 1'b0);
    check_bit("pkt_for_me_o after soft reset", pkt_for_me, 1'b0);
    reg_read(xpu_pkg::REG_SOFT_RST, rb);
    check_word("reg_rdata_o soft reset", rb, 32'h0000_0008);
    reg_write(xpu_pkg::REG_SOFT_RST, 32'h0);
    run_frame(1'b0, 1'b0);   // parser works again after release
  endtask

  task automatic add_row(input logic [1:0] kind, input xpu_pkg::reg_addr_t addr,
                         input xpu_pkg::reg_data_t data, input xpu_pkg::reg_data_t exp);
    stim_row_t r;
    r.kind       = kind;
    r.addr       = addr;
    r.data       = data;
    r.expect_val = exp;
    rows.push_back(r);
  endtask

  task automatic build_table();
    xpu_pkg::reg_data_t mac_lo;
    xpu_pkg::reg_data_t mac_hi;
    xpu_pkg::reg_data_t ifs;
    mac_lo = $urandom;
    mac_hi = $urandom;
    ifs    = {1'b1, 7'd25, 5'd8, 5'd13, 7'd16, 7'd0};   // en, pre, sym, slot, sifs
    add_row(ROW_READ,  xpu_pkg::REG_VERSION, '0, 32'h0000_0A01);
    add_row(ROW_READ,  6'd20, '0, '0);                   // unimplemented
    add_row(ROW_READ,  xpu_pkg::REG_BAND_CH, '0, '0);
    add_row(ROW_WRITE, xpu_pkg::REG_BAND_CH, 32'h0001_0006, '0);   // 2.4 GHz long slot
    add_row(ROW_READ,  xpu_pkg::REG_BAND_CH, '0, 32'h0001_0006);
    add_row(ROW_WRITE, xpu_pkg::REG_BAND_CH, 32'h0101_000B, '0);   // short slot
    add_row(ROW_READ,  xpu_pkg::REG_BAND_CH, '0, 32'h0101_000B);
    add_row(ROW_WRITE, xpu_pkg::REG_BAND_CH, 32'h0002_0024, '0);   // band 2
    add_row(ROW_READ,  xpu_pkg::REG_BAND_CH, '0, 32'h0002_0024);
    add_row(ROW_WRITE, xpu_pkg::REG_MAC_LO, mac_lo, '0);
    add_row(ROW_READ,  xpu_pkg::REG_MAC_LO, '0, mac_lo);
    add_row(ROW_WRITE, xpu_pkg::REG_MAC_HI, mac_hi, '0);
    add_row(ROW_READ,  xpu_pkg::REG_MAC_HI, '0, mac_hi);
    add_row(ROW_WRITE, xpu_pkg::REG_IFS_OVR, ifs, '0);
    add_row(ROW_READ,  xpu_pkg::REG_IFS_OVR, '0, ifs);
    add_row(ROW_WRITE, xpu_pkg::REG_IFS_OVR, '0, '0);
    add_row(ROW_READ,  xpu_pkg::REG_IFS_OVR, '0, '0);
    add_row(ROW_WRITE, xpu_pkg::REG_BAND_CH, 32'h0001_0001, '0);
    add_row(ROW_WRITE, xpu_pkg::REG_VERSION, 32'hFFFF_FFFF, '0);   // read-only
    add_row(ROW_READ,  xpu_pkg::REG_VERSION, '0, 32'h0000_0A01);
    add_row(ROW_FRAME, '0, 32'h1, 32'h1);
    add_row(ROW_FRAME, '0, 32'h0, 32'h0);
    add_row(ROW_FRAME, '0, 32'h1, 32'h1);
  endtask

  initial begin
    xpu_pkg::reg_data_t rdata;
    reg_wr      = 1'b0;
    reg_addr    = '0;
    reg_wdata   = '0;
    hdr_strobe  = 1'b0;
    byte_strobe = 1'b0;
    byte_in     = '0;
    byte_count  = '0;
    void'($urandom(SEED));
    build_table();
    cycle_limit = rows.size() * 40 + RST_CYCLES + 200;

    @(negedge rst);
    check_tsf("tsf_o after reset", tsf, '0);
    check_bit("tsf_pulse_1m_o after reset", tsf_pulse, 1'b0);
    check_valids(1'b0, 1'b0, 1'b0);
    check_word("reg_rdata_o after reset", reg_rdata, '0);
    next_cycle();

    foreach (rows[i]) begin
      case (rows[i].kind)
        ROW_WRITE: begin
          reg_write(rows[i].addr, rows[i].data);
          check_config();
        end
        ROW_READ: begin
          reg_read(rows[i].addr, rdata);
          check_word($sformatf("reg_rdata_o[%0d]", rows[i].addr), rdata, rows[i].expect_val);
        end
        default: run_frame(rows[i].data[0], rows[i].expect_val[0]);
      endcase
    end
    run_tsf_checks();
    run_clear_checks();

    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
